//--- logic/hmc_flit_pkg.sv
`default_nettype none

package hmc_flit_pkg;

  // --------------------
  // Link constants
  // --------------------

  // Four FLITs per link beat, FLIT0 leaves first
  localparam int FLITS_PER_BEAT = 4;
  localparam int FLIT_W = 128;

  // Hold-off counter bit that ends the settle time (256 cycles)
  localparam int SETTLE_BIT = 8;

  // --------------------
  // Command codes
  // --------------------

  // 32-byte posted write, three FLITs, no response
  localparam logic [5:0] CMD_P_WR32 = 6'b011001;
  // 32-byte read, one FLIT, answered by a three FLIT response
  localparam logic [5:0] CMD_RD32 = 6'b110001;

  localparam logic [3:0] LNG_WR32 = 4'd3;
  localparam logic [3:0] LNG_RD32 = 4'd1;

  // Posted writes carry a fixed tag, the memory never answers them
  localparam logic [8:0] WR_TAG = 9'd1;

  // --------------------
  // Basic types
  // --------------------

  // Address in 32-byte units
  typedef logic [26:0] hmc_addr_t;
  typedef logic [8:0] hmc_tag_t;
  typedef logic [255:0] hmc_data_t;

  // Request header, also used for response headers
  typedef struct packed {
    logic [2:0]  cub;
    logic [2:0]  res_hi;
    logic [33:0] addr;
    hmc_tag_t    tag;
    logic [3:0]  dln;
    logic [3:0]  lng;
    logic        res_lo;
    logic [5:0]  cmd;
  } req_hdr_t;

  // One FLIT, seen as raw payload or as header plus upper half
  // Upper half is the tail or the first 64 data bits
  typedef union packed {
    logic [FLIT_W-1:0] raw;
    struct packed {
      logic [FLIT_W/2-1:0] upper;
      req_hdr_t            hdr;
    } hf;
  } flit_t;

  // Per FLIT flags, bit n refers to FLIT n
  typedef struct packed {
    logic [FLITS_PER_BEAT-1:0] tail;
    logic [FLITS_PER_BEAT-1:0] hdr;
    logic [FLITS_PER_BEAT-1:0] valid;
  } flit_user_t;

  // Full link beat, FLIT0 in the low bits
  typedef struct packed {
    flit_user_t user;
    flit_t      flit3;
    flit_t      flit2;
    flit_t      flit1;
    flit_t      flit0;
  } link_beat_t;

  // --------------------
  // User side requests
  // --------------------

  typedef struct packed {
    hmc_addr_t addr;
    hmc_data_t data;
  } wr_req_t;

  typedef struct packed {
    hmc_addr_t addr;
    hmc_tag_t  tag;
  } rd_req_t;

  // Read response back to the user
  typedef struct packed {
    hmc_tag_t  tag;
    hmc_data_t data;
  } rd_rsp_t;

endpackage

`default_nettype wire

//--- logic/hmc_link_startup.sv
`timescale 1ns/1ps
`default_nettype none

module hmc_link_startup (
  input  logic CLK,
  input  logic RST,
  input  logic post_done_i,
  input  logic tx_ready_i,
  output logic link_up_o
);

  // Sequencer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_LINK,
    ST_UP
  } state_t;

  state_t state;
  // Settle counter, advances only while init done is reported
  logic [hmc_flit_pkg::SETTLE_BIT:0] settle_cnt;

  always_ff @(posedge CLK) begin
    if (RST) begin
      state      <= ST_IDLE;
      settle_cnt <= '0;
    end else begin
      case (state)
        // Let controller and memory settle before any request
        ST_IDLE: begin
          if (post_done_i) begin
            settle_cnt <= settle_cnt + 1'b1;
          end
          if (settle_cnt[hmc_flit_pkg::SETTLE_BIT]) begin
            state <= ST_WAIT_LINK;
          end
        end
        // Transmit side must accept beats
        ST_WAIT_LINK: begin
          if (tx_ready_i) begin
            state <= ST_UP;
          end
        end
        // Stays up until the next reset
        ST_UP: state <= ST_UP;
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign link_up_o = (state == ST_UP);

endmodule

`default_nettype wire

//--- logic/hmc_req_packer.sv
`timescale 1ns/1ps
`default_nettype none

module hmc_req_packer (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     link_up_i,
  input  logic                     tx_ready_i,
  input  logic                     wr_valid_i,
  input  hmc_flit_pkg::wr_req_t    wr_req_i,
  input  logic                     rd_valid_i,
  input  hmc_flit_pkg::rd_req_t    rd_req_i,
  output logic                     wr_ready_o,
  output logic                     rd_ready_o,
  output logic                     tx_valid_o,
  output hmc_flit_pkg::link_beat_t tx_beat_o
);

  logic wr_take;
  logic rd_take;
  hmc_flit_pkg::link_beat_t beat_next;

  // Header with zero cube ID and the address shifted to byte units
  function automatic hmc_flit_pkg::req_hdr_t make_hdr(
    input logic [5:0]              cmd,
    input logic [3:0]              lng,
    input hmc_flit_pkg::hmc_addr_t addr,
    input hmc_flit_pkg::hmc_tag_t  tag
  );
    hmc_flit_pkg::req_hdr_t hdr;
    hdr      = '0;
    hdr.addr = {2'b00, addr, 5'b00000};
    hdr.tag  = tag;
    hdr.dln  = lng;
    hdr.lng  = lng;
    hdr.cmd  = cmd;
    return hdr;
  endfunction

  // Both ports open only once the link is up and the controller accepts
  assign wr_ready_o = link_up_i & tx_ready_i;
  assign rd_ready_o = link_up_i & tx_ready_i;

  // Strobes while not ready are dropped
  assign wr_take = wr_valid_i & wr_ready_o;
  assign rd_take = rd_valid_i & rd_ready_o;

  // --------------------
  // Beat assembly
  // --------------------
  always_comb begin
    beat_next = '0;
    // Write in FLITs 0 to 2: header, data, zero tail
    if (wr_take) begin
      beat_next.flit0.hf.hdr   = make_hdr(hmc_flit_pkg::CMD_P_WR32, hmc_flit_pkg::LNG_WR32,
                                          wr_req_i.addr, hmc_flit_pkg::WR_TAG);
      beat_next.flit0.hf.upper = wr_req_i.data[63:0];
      beat_next.flit1.raw      = wr_req_i.data[191:64];
      beat_next.flit2.raw      = {64'h0, wr_req_i.data[255:192]};
      beat_next.user.valid[2:0] = 3'b111;
      beat_next.user.hdr[2:0]   = 3'b001;
      beat_next.user.tail[2:0]  = 3'b100;
    end
    // Read is a single FLIT, header and tail both in FLIT3
    if (rd_take) begin
      beat_next.flit3.hf.hdr   = make_hdr(hmc_flit_pkg::CMD_RD32, hmc_flit_pkg::LNG_RD32,
                                          rd_req_i.addr, rd_req_i.tag);
      beat_next.flit3.hf.upper = '0;
      beat_next.user.valid[3]  = 1'b1;
      beat_next.user.hdr[3]    = 1'b1;
      beat_next.user.tail[3]   = 1'b1;
    end
  end

  // Strobe for one cycle after any accepted request
  always_ff @(posedge CLK) begin
    if (RST) begin
      tx_valid_o <= 1'b0;
    end else begin
      tx_valid_o <= wr_take | rd_take;
    end
  end

  // Beat payload
  always_ff @(posedge CLK) begin
    tx_beat_o <= beat_next;
  end

endmodule

`default_nettype wire

//--- logic/hmc_rsp_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module hmc_rsp_unpacker (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     post_done_i,
  input  logic                     rx_valid_i,
  input  hmc_flit_pkg::link_beat_t rx_beat_i,
  output logic                     rx_ready_o,
  output logic                     rsp_valid_o,
  output hmc_flit_pkg::rd_rsp_t    rd_rsp_o
);

  // Beats are only decoded after init done was seen
  logic armed;
  logic beat_ok;
  hmc_flit_pkg::flit_user_t usr;

  // Start layouts of a response in this beat
  logic lay_a;
  logic lay_b;
  logic lay_c;
  logic lay_d;
  // Second half of a split response
  logic fin_c;
  logic fin_d;

  // Split response held between beats
  logic pend_c;
  logic pend_d;
  hmc_flit_pkg::hmc_tag_t part_tag;
  logic [191:0] part_data;

  logic rsp_hit;
  hmc_flit_pkg::rd_rsp_t rsp_next;

  assign beat_ok = rx_valid_i & armed;
  assign usr     = rx_beat_i.user;

  // --------------------
  // Layout detection
  // --------------------

  // A: header FLIT0, tail FLIT2
  assign lay_a = beat_ok && usr.tail[2:0] == 3'b100 && usr.hdr[2:0] == 3'b001 &&
                 usr.valid[2:0] == 3'b111;
  // B: header FLIT1, tail FLIT3
  assign lay_b = beat_ok && usr.tail[3:1] == 3'b100 && usr.hdr[3:1] == 3'b001 &&
                 usr.valid[3:1] == 3'b111;
  // C: header FLIT2, no tail yet
  assign lay_c = beat_ok && usr.tail[3:2] == 2'b00 && usr.hdr[3:2] == 2'b01 &&
                 usr.valid[3:2] == 2'b11;
  // D: header FLIT3, no tail yet
  assign lay_d = beat_ok && !usr.tail[3] && usr.hdr[3] && usr.valid[3];

  // C ends with tail in FLIT0
  assign fin_c = beat_ok && pend_c && usr.tail[0] && !usr.hdr[0] && usr.valid[0];
  // D ends with tail in FLIT1
  assign fin_d = beat_ok && pend_d && usr.tail[1:0] == 2'b10 && usr.hdr[1:0] == 2'b00 &&
                 usr.valid[1:0] == 2'b11;

  // --------------------
  // Response assembly
  // --------------------
  always_comb begin
    rsp_hit  = 1'b1;
    rsp_next = '0;
    if (fin_c) begin
      // Last 64 data bits sit in the low half of FLIT0
      rsp_next.tag  = part_tag;
      rsp_next.data = {rx_beat_i.flit0.raw[63:0], part_data};
    end else if (fin_d) begin
      rsp_next.tag  = part_tag;
      rsp_next.data = {rx_beat_i.flit1.raw[63:0], rx_beat_i.flit0.raw, part_data[63:0]};
    end else if (lay_a) begin
      rsp_next.tag  = rx_beat_i.flit0.hf.hdr.tag;
      rsp_next.data = {rx_beat_i.flit2.raw[63:0], rx_beat_i.flit1.raw,
                       rx_beat_i.flit0.hf.upper};
    end else if (lay_b) begin
      rsp_next.tag  = rx_beat_i.flit1.hf.hdr.tag;
      rsp_next.data = {rx_beat_i.flit3.raw[63:0], rx_beat_i.flit2.raw,
                       rx_beat_i.flit1.hf.upper};
    end else begin
      rsp_hit = 1'b0;
    end
  end

  // Control state
  always_ff @(posedge CLK) begin
    if (RST) begin
      armed       <= 1'b0;
      rx_ready_o  <= 1'b0;
      pend_c      <= 1'b0;
      pend_d      <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      // Always ready once out of reset
      rx_ready_o  <= 1'b1;
      armed       <= armed | post_done_i;
      rsp_valid_o <= rsp_hit;
      // Pending state moves only on decoded beats
      if (beat_ok) begin
        pend_c <= lay_c;
        pend_d <= lay_d;
      end
    end
  end

  // Payload registers
  always_ff @(posedge CLK) begin
    if (rsp_hit) begin
      rd_rsp_o <= rsp_next;
    end
    if (lay_c) begin
      // Data FLIT3 plus upper half of FLIT2
      part_tag  <= rx_beat_i.flit2.hf.hdr.tag;
      part_data <= {rx_beat_i.flit3.raw, rx_beat_i.flit2.hf.upper};
    end else if (lay_d) begin
      part_tag        <= rx_beat_i.flit3.hf.hdr.tag;
      part_data[63:0] <= rx_beat_i.flit3.hf.upper;
    end
  end

endmodule

`default_nettype wire

//--- logic/hmc_flit_top.sv
`timescale 1ns/1ps
`default_nettype none

module hmc_flit_top (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     post_done_i,
  // Transmit link
  input  logic                     tx_ready_i,
  output logic                     tx_valid_o,
  output hmc_flit_pkg::link_beat_t tx_beat_o,
  // Receive link
  input  logic                     rx_valid_i,
  input  hmc_flit_pkg::link_beat_t rx_beat_i,
  output logic                     rx_ready_o,
  // Write port
  input  logic                     wr_valid_i,
  input  hmc_flit_pkg::wr_req_t    wr_req_i,
  output logic                     wr_ready_o,
  // Read port
  input  logic                     rd_valid_i,
  input  hmc_flit_pkg::rd_req_t    rd_req_i,
  output logic                     rd_ready_o,
  // Read responses
  output logic                     rsp_valid_o,
  output hmc_flit_pkg::rd_rsp_t    rd_rsp_o
);

  // Gates all request traffic
  logic link_up;

  hmc_link_startup u_startup (
    .CLK         (CLK),
    .RST         (RST),
    .post_done_i (post_done_i),
    .tx_ready_i  (tx_ready_i),
    .link_up_o   (link_up)
  );

  hmc_req_packer u_packer (
    .CLK        (CLK),
    .RST        (RST),
    .link_up_i  (link_up),
    .tx_ready_i (tx_ready_i),
    .wr_valid_i (wr_valid_i),
    .wr_req_i   (wr_req_i),
    .rd_valid_i (rd_valid_i),
    .rd_req_i   (rd_req_i),
    .wr_ready_o (wr_ready_o),
    .rd_ready_o (rd_ready_o),
    .tx_valid_o (tx_valid_o),
    .tx_beat_o  (tx_beat_o)
  );

  hmc_rsp_unpacker u_unpacker (
    .CLK         (CLK),
    .RST         (RST),
    .post_done_i (post_done_i),
    .rx_valid_i  (rx_valid_i),
    .rx_beat_i   (rx_beat_i),
    .rx_ready_o  (rx_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rd_rsp_o    (rd_rsp_o)
  );

endmodule

`default_nettype wire

//--- bench/tb_hmc_flit_checks.svh
`ifndef TB_HMC_FLIT_CHECKS_SVH
`define TB_HMC_FLIT_CHECKS_SVH

// --------------------
// Failure handling
// --------------------

// Report the error line and end the run at the first failure
task automatic fail_run(input string line);
  $display("%s", line);
  $display("Test failures found");
  $fatal(1, "stopped at first error");
endtask

// One clock cycle, inputs change 1 ns after the rising edge
task automatic step();
  @(posedge CLK);
  #1;
endtask

// --------------------
// Typed compares
// --------------------

// Single strobe or ready level
task automatic check_bit(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    fail_run($sformatf("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp));
  end
endtask

// Whole transmit beat, flags included
task automatic check_beat(input string what, input hmc_flit_pkg::link_beat_t got,
                          input hmc_flit_pkg::link_beat_t exp);
  if (got !== exp) begin
    fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp));
  end
endtask

// Tag and data of one read response
task automatic check_rsp(input string what, input hmc_flit_pkg::rd_rsp_t got,
                         input hmc_flit_pkg::rd_rsp_t exp);
  if (got !== exp) begin
    fail_run($sformatf("mismatch at %0t ns: %s got tag %h data %h expected tag %h data %h",
                       $time, what, got.tag, got.data, exp.tag, exp.data));
  end
endtask

// --------------------
// Bounded waits
// --------------------

// Both request ports open, cycles counts the edges waited
task automatic wait_ready(input int limit, output int cycles);
  cycles = 0;
  while (!(wr_ready && rd_ready)) begin
    if (cycles >= limit) begin
      fail_run("timeout: write and read ports never opened");
    end
    step();
    cycles++;
  end
endtask

`endif

//--- bench/tb_hmc_flit_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hmc_flit_top;

  logic CLK = 1'b0;
  logic RST;
  logic post_done;
  logic tx_ready;
  logic tx_valid;
  logic rx_valid;
  logic rx_ready;
  logic wr_valid;
  logic wr_ready;
  logic rd_valid;
  logic rd_ready;
  logic rsp_valid;
  hmc_flit_pkg::link_beat_t tx_beat;
  hmc_flit_pkg::link_beat_t rx_beat;
  hmc_flit_pkg::wr_req_t wr_req;
  hmc_flit_pkg::rd_req_t rd_req;
  hmc_flit_pkg::rd_rsp_t rd_rsp;

  // 4 ns clock
  always #2 CLK = ~CLK;

  hmc_flit_top dut_i (
    .CLK (CLK), .RST (RST), .post_done_i (post_done),
    .tx_ready_i (tx_ready), .tx_valid_o (tx_valid), .tx_beat_o (tx_beat),
    .rx_valid_i (rx_valid), .rx_beat_i (rx_beat), .rx_ready_o (rx_ready),
    .wr_valid_i (wr_valid), .wr_req_i (wr_req), .wr_ready_o (wr_ready),
    .rd_valid_i (rd_valid), .rd_req_i (rd_req), .rd_ready_o (rd_ready),
    .rsp_valid_o (rsp_valid), .rd_rsp_o (rd_rsp)
  );

  `include "tb_hmc_flit_checks.svh"

  // --------------------
  // Expected values
  // --------------------

  // Header built from its fields in order cube, res, addr, tag, dln, lng, res, cmd
  function automatic logic [63:0] hdr_word(input logic [5:0] cmd, input logic [3:0] lng,
                                           input hmc_flit_pkg::hmc_addr_t addr,
                                           input hmc_flit_pkg::hmc_tag_t tag);
    return {3'b000, 3'b000, 2'b00, addr, 5'b00000, tag, lng, lng, 1'b0, cmd};
  endfunction

  function automatic hmc_flit_pkg::hmc_data_t rand_data();
    hmc_flit_pkg::hmc_data_t d;
    for (int i = 0; i < 8; i++) begin
      d[i*32 +: 32] = $urandom;
    end
    return d;
  endfunction

  function automatic logic [31:0] rand_word();
    return $urandom;
  endfunction

  // Posted write with the header in FLIT0 and data up to the low half of FLIT2
  function automatic hmc_flit_pkg::link_beat_t write_beat(input hmc_flit_pkg::wr_req_t req);
    hmc_flit_pkg::link_beat_t b;
    b = '0;
    b.flit0.raw = {req.data[63:0], hdr_word(hmc_flit_pkg::CMD_P_WR32,
                   hmc_flit_pkg::LNG_WR32, req.addr, hmc_flit_pkg::WR_TAG)};
    b.flit1.raw = req.data[191:64];
    b.flit2.raw = {64'h0, req.data[255:192]};
    b.user.valid = 4'b0111;
    b.user.hdr   = 4'b0001;
    b.user.tail  = 4'b0100;
    return b;
  endfunction

  // Read request alone in FLIT3
  function automatic hmc_flit_pkg::link_beat_t read_beat(input hmc_flit_pkg::rd_req_t req);
    hmc_flit_pkg::link_beat_t b;
    b = '0;
    b.flit3.raw = {64'h0, hdr_word(hmc_flit_pkg::CMD_RD32, hmc_flit_pkg::LNG_RD32,
                                   req.addr, req.tag)};
    b.user = '{tail: 4'b1000, hdr: 4'b1000, valid: 4'b1000};
    return b;
  endfunction

  // Layout A in FLITs 0 to 2 and layout B in FLITs 1 to 3
  function automatic hmc_flit_pkg::link_beat_t whole_rsp(input logic at_flit1,
                                                         input hmc_flit_pkg::rd_rsp_t rsp);
    hmc_flit_pkg::link_beat_t b;
    logic [127:0] f_hdr;
    logic [127:0] f_tail;
    b = '0;
    // Read response command 0x38 with length 3
    f_hdr  = {rsp.data[63:0], hdr_word(6'h38, 4'd3, 27'd0, rsp.tag)};
    // Random tail bits that the unpacker must ignore
    f_tail = {rand_word(), rand_word(), rsp.data[255:192]};
    if (at_flit1) begin
      b.flit1.raw = f_hdr;
      b.flit2.raw = rsp.data[191:64];
      b.flit3.raw = f_tail;
      b.user = '{tail: 4'b1000, hdr: 4'b0010, valid: 4'b1110};
    end else begin
      b.flit0.raw = f_hdr;
      b.flit1.raw = rsp.data[191:64];
      b.flit2.raw = f_tail;
      b.user = '{tail: 4'b0100, hdr: 4'b0001, valid: 4'b0111};
    end
    return b;
  endfunction

  // Layout C starts in FLIT2 and layout D in FLIT3 and both finish in the next beat
  function automatic void split_rsp(input logic at_flit3, input hmc_flit_pkg::rd_rsp_t rsp,
                                    output hmc_flit_pkg::link_beat_t first,
                                    output hmc_flit_pkg::link_beat_t second);
    logic [127:0] f_hdr;
    first  = '0;
    second = '0;
    f_hdr  = {rsp.data[63:0], hdr_word(6'h38, 4'd3, 27'd0, rsp.tag)};
    if (at_flit3) begin
      first.flit3.raw  = f_hdr;
      first.user       = '{tail: 4'b0000, hdr: 4'b1000, valid: 4'b1000};
      second.flit0.raw = rsp.data[191:64];
      second.flit1.raw = {rand_word(), rand_word(), rsp.data[255:192]};
      second.user      = '{tail: 4'b0010, hdr: 4'b0000, valid: 4'b0011};
    end else begin
      first.flit2.raw  = f_hdr;
      first.flit3.raw  = rsp.data[191:64];
      first.user       = '{tail: 4'b0000, hdr: 4'b0100, valid: 4'b1100};
      second.flit0.raw = {rand_word(), rand_word(), rsp.data[255:192]};
      second.user      = '{tail: 4'b0001, hdr: 4'b0000, valid: 4'b0001};
    end
  endfunction

  // --------------------
  // Directed tests
  // --------------------

  task automatic reset_dut();
    repeat (3) step();
    check_bit("tx_valid_o in reset", tx_valid, 1'b0);
    check_bit("rsp_valid_o in reset", rsp_valid, 1'b0);
    check_bit("wr_ready_o in reset", wr_ready, 1'b0);
    check_bit("rd_ready_o in reset", rd_ready, 1'b0);
    check_bit("rx_ready_o in reset", rx_ready, 1'b0);
    RST = 1'b0;
  endtask

  task automatic test_startup();
    int cycles;
    // Ports stay shut well past the settle time without init done
    repeat (300) begin
      step();
      check_bit("wr_ready_o before init done", wr_ready, 1'b0);
      check_bit("rd_ready_o before init done", rd_ready, 1'b0);
    end
    check_bit("rx_ready_o after reset", rx_ready, 1'b1);
    post_done = 1'b1;
    wait_ready(400, cycles);
    if (cycles < 256) begin
      fail_run($sformatf("mismatch at %0t ns: ports opened after %0d cycles, expected 256 or more",
                         $time, cycles));
    end
  endtask

  // Write alone, read alone or both in one cycle
  task automatic test_requests(input logic do_wr, input logic do_rd, input string name);
    hmc_flit_pkg::link_beat_t exp;
    hmc_flit_pkg::link_beat_t rd_part;
    wr_req   = '{addr: rand_word() >> 5, data: rand_data()};
    rd_req   = '{addr: rand_word() >> 5, tag: rand_word() >> 23};
    wr_valid = do_wr;
    rd_valid = do_rd;
    exp      = do_wr ? write_beat(wr_req) : '0;
    rd_part  = read_beat(rd_req);
    if (do_rd) begin
      exp.flit3 = rd_part.flit3;
      exp.user  = exp.user | rd_part.user;
    end
    step();
    check_bit({name, " tx_valid_o"}, tx_valid, 1'b1);
    check_beat({name, " beat"}, tx_beat, exp);
    wr_valid = 1'b0;
    rd_valid = 1'b0;
    step();
    check_bit({name, " tx_valid_o drops"}, tx_valid, 1'b0);
  endtask

  task automatic test_ready_gate();
    tx_ready = 1'b0;
    wr_valid = 1'b1;
    rd_valid = 1'b1;
    repeat (4) begin
      step();
      check_bit("wr_ready_o with tx_ready_i low", wr_ready, 1'b0);
      check_bit("rd_ready_o with tx_ready_i low", rd_ready, 1'b0);
      check_bit("tx_valid_o with tx_ready_i low", tx_valid, 1'b0);
    end
    wr_valid = 1'b0;
    rd_valid = 1'b0;
    tx_ready = 1'b1;
    // Readies are the link state ANDed with tx_ready_i, so they reopen at once
    step();
    check_bit("wr_ready_o after tx_ready_i returns", wr_ready, 1'b1);
    check_bit("rd_ready_o after tx_ready_i returns", rd_ready, 1'b1);
  endtask

  task automatic test_rsp(input logic split, input logic late, input string name);
    hmc_flit_pkg::rd_rsp_t rsp;
    hmc_flit_pkg::link_beat_t first;
    hmc_flit_pkg::link_beat_t second;
    rsp = '{tag: rand_word() >> 23, data: rand_data()};
    rx_valid = 1'b1;
    if (split) begin
      split_rsp(late, rsp, first, second);
      rx_beat = first;
      // Nothing leaves until the tail beat arrives
      step();
      check_bit({name, " rsp_valid_o after first beat"}, rsp_valid, 1'b0);
      rx_beat = second;
    end else begin
      rx_beat = whole_rsp(late, rsp);
    end
    step();
    check_bit({name, " rsp_valid_o"}, rsp_valid, 1'b1);
    check_rsp({name, " response"}, rd_rsp, rsp);
    rx_valid = 1'b0;
    rx_beat  = '0;
    step();
    check_bit({name, " rsp_valid_o drops"}, rsp_valid, 1'b0);
  endtask

  initial begin
    void'($urandom(32'hc3b7_1592));
    RST       = 1'b1;
    post_done = 1'b0;
    tx_ready  = 1'b1;
    wr_valid  = 1'b0;
    wr_req    = '0;
    rd_valid  = 1'b0;
    rd_req    = '0;
    rx_valid  = 1'b0;
    rx_beat   = '0;
    reset_dut();
    test_startup();
    test_requests(1'b1, 1'b0, "posted write");
    test_requests(1'b0, 1'b1, "read");
    test_requests(1'b1, 1'b1, "write with read");
    test_ready_gate();
    test_rsp(1'b0, 1'b0, "layout A");
    test_rsp(1'b0, 1'b1, "layout B");
    test_rsp(1'b1, 1'b0, "layout C");
    test_rsp(1'b1, 1'b1, "layout D");
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+bench
logic/hmc_flit_pkg.sv
logic/hmc_link_startup.sv
logic/hmc_req_packer.sv
logic/hmc_rsp_unpacker.sv
logic/hmc_flit_top.sv
bench/tb_hmc_flit_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run, the exit status gives pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_hmc_flit_top \
  -o sim_tb_hmc_flit_top && ./obj_dir/sim_tb_hmc_flit_top || exit 1
